/* hw/lander_pkg.sv */
////////////////////
// lander shell shared definitions
// controller, cabinet, raster and display types
// plus thrust, banner and colour constants
////////////////////

`default_nettype none

package lander_pkg;

  ////////////////////
  // widths and timing

  // game colour depth per channel
  localparam int COLOR_W = 3;
  localparam int THRUST_W = 8;
  // thrust ceiling, one below full scale as on the cabinet
  localparam int THRUST_MAX = 254;
  // zero to full thrust in about one second at 50 MHz
  localparam int THRUST_TICK_CYCLES = 196_850;
  // banner lifetime, 10 s of clk_50
  localparam int BANNER_CYCLES = 500_000_000;
  // box size in active pixels and lines
  localparam int BANNER_COLS = 32;
  localparam int BANNER_LINES = 8;
  localparam int POS_W = 10;

  ////////////////////
  // types

  // controller bitmap, bit 0 is dpad up
  typedef struct packed {
    logic face_start;
    logic face_select;
    logic trig_r3;
    logic trig_l3;
    logic trig_r2;
    logic trig_l2;
    logic trig_r1;
    logic trig_l1;
    logic face_y;
    logic face_x;
    logic face_b;
    logic face_a;
    logic dpad_right;
    logic dpad_left;
    logic dpad_down;
    logic dpad_up;
  } cont_keys_t;

  // raw game raster, syncs active low
  typedef struct packed {
    logic [COLOR_W-1:0] r;
    logic [COLOR_W-1:0] g;
    logic [COLOR_W-1:0] b;
    logic hs_n;
    logic vs_n;
    logic hblank;
    logic vblank;
  } game_video_t;

  // difficulty lamps
  typedef struct packed {
    logic lamp5;
    logic lamp4;
    logic lamp3;
  } lamps_t;

  // cabinet inputs, all active low
  typedef struct packed {
    logic turn_l_n;
    logic turn_r_n;
    logic abort_n;
    logic coin_n;
    logic select_n;
    logic start_n;
  } cab_buttons_t;

  typedef logic [23:0] rgb_t;

  // display stream, one-cycle sync pulses
  typedef struct packed {
    rgb_t rgb;
    logic de;
    logic hs;
    logic vs;
  } disp_pixel_t;

  // box colour per level: blue, green, yellow, red
  localparam rgb_t DIFF_COLORS [4] = '{24'h0000ff, 24'h00ff00, 24'hffff00, 24'hff0000};

endpackage

`default_nettype wire

/* hw/lander_controls.sv */
////////////////////
// lander controls
// syncs both handhelds, maps cabinet buttons
// and ramps thrust from face a / face b
////////////////////

`default_nettype none

module lander_controls #(
  parameter int TICK_CYCLES = lander_pkg::THRUST_TICK_CYCLES
) (
  input  wire                             clk_50,
  input  wire                             i_rst,
  input  wire lander_pkg::cont_keys_t     i_cont1_key,
  input  wire lander_pkg::cont_keys_t     i_cont2_key,
  output lander_pkg::cab_buttons_t        o_buttons,
  output logic [lander_pkg::THRUST_W-1:0] o_thrust
);

  localparam int TICK_W = $clog2(TICK_CYCLES + 1);

  lander_pkg::cont_keys_t c1_meta;
  lander_pkg::cont_keys_t c1_sync;
  lander_pkg::cont_keys_t c2_meta;
  lander_pkg::cont_keys_t c2_sync;
  lander_pkg::cont_keys_t keys;
  logic [TICK_W-1:0] tick_cnt;
  logic tick;

  // two-flop sync per controller
  always_ff @(posedge clk_50) begin
    if (i_rst) begin
      c1_meta <= '0;
      c1_sync <= '0;
      c2_meta <= '0;
      c2_sync <= '0;
    end else begin
      c1_meta <= i_cont1_key;
      c1_sync <= c1_meta;
      c2_meta <= i_cont2_key;
      c2_sync <= c2_meta;
    end
  end

  // either controller may play
  assign keys = c1_sync | c2_sync;

  // cabinet side wants active low
  always_comb begin
    o_buttons.turn_l_n = ~keys.dpad_left;
    o_buttons.turn_r_n = ~keys.dpad_right;
    o_buttons.abort_n  = ~keys.trig_r1;
    o_buttons.coin_n   = ~keys.trig_l1;
    o_buttons.select_n = ~keys.face_select;
    o_buttons.start_n  = ~keys.face_start;
  end

  ////////////////////
  // thrust ramp

  assign tick = (tick_cnt == TICK_W'(TICK_CYCLES - 1));

  always_ff @(posedge clk_50) begin
    if (i_rst) begin
      tick_cnt <= '0;
      o_thrust <= '0;
    end else begin
      tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
      // one step per tick, raise has priority
      if (tick) begin
        if (keys.face_a) begin
          if (o_thrust < lander_pkg::THRUST_W'(lander_pkg::THRUST_MAX))
            o_thrust <= o_thrust + 1'b1;
        end else if (keys.face_b && o_thrust != '0) begin
          o_thrust <= o_thrust - 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hw/pixel_expand.sv */
////////////////////
// pixel expand
// 3-bit game colour to 24-bit stream
// with de and sync-start pulses
////////////////////

`default_nettype none

module pixel_expand (
  input  wire                          clk_50,
  input  wire                          i_rst,
  input  wire lander_pkg::game_video_t i_game,
  output lander_pkg::disp_pixel_t      o_pixel
);

  // bit replication, keeps full white at ff
  function automatic logic [7:0] widen(input logic [lander_pkg::COLOR_W-1:0] c);
    widen = {c, c, c[lander_pkg::COLOR_W-1 -: 2]};
  endfunction

  logic hs_n_q;
  logic vs_n_q;
  logic active;

  assign active = ~(i_game.hblank | i_game.vblank);

  always_ff @(posedge clk_50) begin
    if (i_rst) begin
      o_pixel <= '0;
      hs_n_q  <= 1'b1;
      vs_n_q  <= 1'b1;
    end else begin
      hs_n_q     <= i_game.hs_n;
      vs_n_q     <= i_game.vs_n;
      o_pixel.de <= active;
      // black outside the active window
      o_pixel.rgb <= active ? {widen(i_game.r), widen(i_game.g), widen(i_game.b)} : '0;
      // single pulse on each falling sync
      o_pixel.hs <= hs_n_q & ~i_game.hs_n;
      o_pixel.vs <= vs_n_q & ~i_game.vs_n;
    end
  end

endmodule

`default_nettype wire

/* hw/difficulty_banner.sv */
////////////////////
// difficulty banner
// top-left box coloured by difficulty level,
// shown for a while after select
////////////////////

`default_nettype none

module difficulty_banner #(
  parameter int HOLD_CYCLES = lander_pkg::BANNER_CYCLES
) (
  input  wire                           clk_50,
  input  wire                           i_rst,
  input  wire lander_pkg::game_video_t  i_game,
  input  wire lander_pkg::cab_buttons_t i_buttons,
  input  wire lander_pkg::lamps_t       i_lamps,
  output logic                          o_box_on,
  output lander_pkg::rgb_t              o_box_rgb
);

  localparam int CNT_W = $clog2(HOLD_CYCLES + 1);
  localparam int POS_W = lander_pkg::POS_W;

  logic [CNT_W-1:0] hold_cnt;
  logic [POS_W-1:0] col;
  logic [POS_W-1:0] line;
  logic [1:0] level;
  logic active;
  logic line_end;
  logic in_box;

  ////////////////////
  // select countdown

  always_ff @(posedge clk_50) begin
    if (i_rst)
      hold_cnt <= '0;
    else if (!i_buttons.select_n)
      hold_cnt <= CNT_W'(HOLD_CYCLES);
    else if (hold_cnt != '0)
      hold_cnt <= hold_cnt - 1'b1;
  end

  ////////////////////
  // raster position

  assign active = ~(i_game.hblank | i_game.vblank);
  // col nonzero means the previous sample was active
  assign line_end = ~active && (col != '0);

  // counters saturate so a long line never wraps into the box
  always_ff @(posedge clk_50) begin
    if (i_rst) begin
      col  <= '0;
      line <= '0;
    end else begin
      if (!active)
        col <= '0;
      else if (col != '1)
        col <= col + 1'b1;
      if (i_game.vblank)
        line <= '0;
      else if (line_end && line != '1)
        line <= line + 1'b1;
    end
  end

  // highest lit lamp wins
  always_comb begin
    if (i_lamps.lamp5)
      level = 2'd3;
    else if (i_lamps.lamp4)
      level = 2'd2;
    else if (i_lamps.lamp3)
      level = 2'd1;
    else
      level = 2'd0;
  end

  assign in_box = active && (hold_cnt != '0) &&
                  (col < POS_W'(lander_pkg::BANNER_COLS)) &&
                  (line < POS_W'(lander_pkg::BANNER_LINES));

  // same sample as pixel_expand, same latency
  always_ff @(posedge clk_50) begin
    if (i_rst)
      o_box_on <= 1'b0;
    else
      o_box_on <= in_box;
    o_box_rgb <= lander_pkg::DIFF_COLORS[level];
  end

endmodule

`default_nettype wire

/* hw/video_mixer.sv */
////////////////////
// video mixer
// box colour over game pixel,
// final display register
////////////////////

`default_nettype none

module video_mixer (
  input  wire                          clk_50,
  input  wire                          i_rst,
  // expanded game pixel
  input  wire lander_pkg::disp_pixel_t i_pixel,
  // banner box, aligned with i_pixel
  input  wire                          i_box_on,
  input  wire lander_pkg::rgb_t        i_box_rgb,
  // to display
  output lander_pkg::disp_pixel_t      o_video
);

  lander_pkg::rgb_t mix_rgb;

  // box only ever lit inside the active window
  // so de needs no change here
  assign mix_rgb = i_box_on ? i_box_rgb : i_pixel.rgb;

  ////////////////////
  // output register

  always_ff @(posedge clk_50) begin
    if (i_rst) begin
      o_video <= '0;
    end else begin
      o_video.rgb <= mix_rgb;
      // timing passes straight through
      o_video.de  <= i_pixel.de;
      o_video.hs  <= i_pixel.hs;
      o_video.vs  <= i_pixel.vs;
    end
  end

endmodule

`default_nettype wire

/* hw/lander_shell.sv */
////////////////////
// lander shell top
// controls, video expand, banner and mixer
////////////////////

`default_nettype none

module lander_shell #(
  parameter int TICK_CYCLES = lander_pkg::THRUST_TICK_CYCLES,
  parameter int HOLD_CYCLES = lander_pkg::BANNER_CYCLES
) (
  input  wire                             clk_50,
  input  wire                             i_rst,
  // host controllers
  input  wire lander_pkg::cont_keys_t     i_cont1_key,
  input  wire lander_pkg::cont_keys_t     i_cont2_key,
  // from the game
  input  wire lander_pkg::game_video_t    i_game,
  input  wire lander_pkg::lamps_t         i_lamps,
  // to the game
  output lander_pkg::cab_buttons_t        o_buttons,
  output logic [lander_pkg::THRUST_W-1:0] o_thrust,
  // to the display
  output lander_pkg::disp_pixel_t         o_video
);

  lander_pkg::disp_pixel_t pixel;
  lander_pkg::rgb_t box_rgb;
  logic box_on;

  lander_controls #(
    .TICK_CYCLES (TICK_CYCLES)
  ) u_controls (
    .clk_50      (clk_50),
    .i_rst       (i_rst),
    .i_cont1_key (i_cont1_key),
    .i_cont2_key (i_cont2_key),
    .o_buttons   (o_buttons),
    .o_thrust    (o_thrust)
  );

  ////////////////////
  // video, two paths then mix

  pixel_expand u_expand (
    .clk_50  (clk_50),
    .i_rst   (i_rst),
    .i_game  (i_game),
    .o_pixel (pixel)
  );

  // banner sees the synced select level
  difficulty_banner #(
    .HOLD_CYCLES (HOLD_CYCLES)
  ) u_banner (
    .clk_50    (clk_50),
    .i_rst     (i_rst),
    .i_game    (i_game),
    .i_buttons (o_buttons),
    .i_lamps   (i_lamps),
    .o_box_on  (box_on),
    .o_box_rgb (box_rgb)
  );

  video_mixer u_mixer (
    .clk_50    (clk_50),
    .i_rst     (i_rst),
    .i_pixel   (pixel),
    .i_box_on  (box_on),
    .i_box_rgb (box_rgb),
    .o_video   (o_video)
  );

endmodule

`default_nettype wire

/* dv/tb_clock.sv */
////////////////////
// testbench clock and reset
// 20-unit clk_50, reset held 4 cycles
////////////////////

`default_nettype none

module tb_clock (
  output logic clk_50,
  output logic o_rst
);

  initial begin
    clk_50 = 1'b0;
    o_rst  = 1'b1;
    repeat (4) @(posedge clk_50);
    // released on a falling edge like the other inputs
    @(negedge clk_50);
    o_rst <= 1'b0;
  end

  always #10 clk_50 = ~clk_50;

endmodule

`default_nettype wire

/* dv/tb_lander_shell.sv */
////////////////////
// lander shell testbench
// keys and raster in with a cycle model of the
// expected outputs checked at falling edges
////////////////////

`default_nettype none

module tb_lander_shell;

  localparam int TICK = 50;
  localparam int HOLD = 400;
  // raster of 40 + 10 columns by 12 + 3 lines
  localparam int COLS = 40;
  localparam int LINE_LEN = 50;
  localparam int LINES = 12;
  localparam int FRAME_LINES = 15;
  localparam int FRAME = LINE_LEN * FRAME_LINES;
  localparam int BOX_PIXELS = 32 * 8;
  localparam logic [7:0] THRUST_TOP = 8'd254;
  // syncs high and both blanks set
  localparam lander_pkg::game_video_t IDLE_VIDEO = 13'h00f;
  // thrust tests sized by ticks and video tests by frames
  localparam int RUN_CYCLES = 200 + 532 * TICK + 15 * (FRAME + 2);
  localparam int WATCHDOG_TIME = (RUN_CYCLES + 2000) * 20;

  logic clk_50;
  logic rst;
  lander_pkg::cont_keys_t cont1;
  lander_pkg::cont_keys_t cont2;
  lander_pkg::game_video_t game;
  lander_pkg::lamps_t lamps;
  lander_pkg::cab_buttons_t buttons;
  logic [7:0] thrust;
  lander_pkg::disp_pixel_t video;

  int seed = 32'h248f_d078;
  int drv_col;
  int drv_line;
  string test_name = "reset";
  int test_errs = 0;
  int total_errs = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int de_seen;
  int lit_seen;
  int hs_seen;
  int vs_seen;
  // controller bit and the cabinet bit it drives
  int key_bit [6] = '{2, 3, 9, 8, 14, 15};
  int cab_bit [6] = '{5, 4, 3, 2, 1, 0};

  // model state
  lander_pkg::cont_keys_t kq1;
  lander_pkg::cont_keys_t kq2;
  lander_pkg::disp_pixel_t s1;
  lander_pkg::disp_pixel_t exp_video;
  lander_pkg::rgb_t s1_box_rgb;
  lander_pkg::cab_buttons_t exp_buttons;
  logic [7:0] exp_thrust;
  logic s1_box;
  logic prev_hs_n;
  logic prev_vs_n;
  logic model_active;
  logic model_live = 1'b0;
  int hold_left;
  int tick_cnt;

  tb_clock u_clock (
    .clk_50 (clk_50),
    .o_rst  (rst)
  );

  lander_shell #(
    .TICK_CYCLES (TICK),
    .HOLD_CYCLES (HOLD)
  ) u_dut (
    .clk_50      (clk_50),
    .i_rst       (rst),
    .i_cont1_key (cont1),
    .i_cont2_key (cont2),
    .i_game      (game),
    .i_lamps     (lamps),
    .o_buttons   (buttons),
    .o_thrust    (thrust),
    .o_video     (video)
  );

  ////////////////////
  // reference rules

  function automatic logic [7:0] expand3to8(input logic [2:0] c);
    return {c, c, c[2:1]};
  endfunction

  // blue, green, yellow, red by highest lamp
  function automatic lander_pkg::rgb_t lamp_colour(input lander_pkg::lamps_t l);
    if (l.lamp5)
      return 24'hff0000;
    if (l.lamp4)
      return 24'hffff00;
    if (l.lamp3)
      return 24'h00ff00;
    return 24'h0000ff;
  endfunction

  // each cabinet bit is the inverse of its mapped key
  function automatic lander_pkg::cab_buttons_t cab_from_keys(input lander_pkg::cont_keys_t k);
    logic [5:0] b;
    logic [15:0] kv;
    kv = k;
    for (int j = 0; j < 6; j++)
      b[cab_bit[j]] = ~kv[key_bit[j]];
    return b;
  endfunction

  // model steps on rising edges where inputs are stable
  always @(posedge clk_50) begin
    if (rst) begin
      kq1 = '0;
      kq2 = '0;
      s1 = '0;
      exp_video = '0;
      s1_box = 1'b0;
      prev_hs_n = 1'b1;
      prev_vs_n = 1'b1;
      hold_left = 0;
      tick_cnt = 0;
      exp_thrust = 8'd0;
    end else begin
      // mixer stage
      exp_video = s1;
      if (s1_box)
        exp_video.rgb = s1_box_rgb;
      // expand stage and box decision
      model_active = !game.hblank && !game.vblank;
      s1.de = model_active;
      s1.rgb = model_active ?
               {expand3to8(game.r), expand3to8(game.g), expand3to8(game.b)} : '0;
      s1.hs = prev_hs_n && !game.hs_n;
      s1.vs = prev_vs_n && !game.vs_n;
      s1_box = model_active && hold_left > 0 && drv_col < 32 && drv_line < 8;
      s1_box_rgb = lamp_colour(lamps);
      prev_hs_n = game.hs_n;
      prev_vs_n = game.vs_n;
      // thrust and countdown follow the synced keys
      if (tick_cnt == TICK - 1) begin
        tick_cnt = 0;
        if (kq2.face_a) begin
          if (exp_thrust < THRUST_TOP)
            exp_thrust = exp_thrust + 8'd1;
        end else if (kq2.face_b && exp_thrust != 8'd0) begin
          exp_thrust = exp_thrust - 8'd1;
        end
      end else begin
        tick_cnt++;
      end
      if (kq2.face_select)
        hold_left = HOLD;
      else if (hold_left > 0)
        hold_left--;
      kq2 = kq1;
      kq1 = cont1 | cont2;
    end
    exp_buttons = cab_from_keys(kq2);
    model_live = 1'b1;
  end

  ////////////////////
  // checks and reporting

  task automatic report_mismatch(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("Error %s %s: expected %h actual %h", test_name, what, expected, actual);
    test_errs++;
  endtask

  task automatic report_problem(input string text);
    $display("%s: %s", test_name, text);
    test_errs++;
  endtask

  always @(negedge clk_50) begin
    if (model_live) begin
      assert (buttons === exp_buttons)
        else report_mismatch("buttons", {26'd0, exp_buttons}, {26'd0, buttons});
      assert (thrust === exp_thrust)
        else report_mismatch("thrust", {24'd0, exp_thrust}, {24'd0, thrust});
      assert (video === exp_video)
        else report_mismatch("video", {5'd0, exp_video}, {5'd0, video});
    end
  end

  task automatic end_test();
    $display("test %-8s done, %0d errors", test_name, test_errs);
    tests_run++;
    if (test_errs != 0)
      tests_failed++;
    total_errs += test_errs;
    test_errs = 0;
  endtask

  ////////////////////
  // stimulus helpers

  task automatic clear_counts();
    de_seen = 0;
    lit_seen = 0;
    hs_seen = 0;
    vs_seen = 0;
  endtask

  // sampled at the falling edge before new inputs
  task automatic sample_outputs();
    if (video.de)
      de_seen++;
    if (video.de && video.rgb != '0)
      lit_seen++;
    if (video.hs)
      hs_seen++;
    if (video.vs)
      vs_seen++;
  endtask

  task automatic settle(input int n);
    repeat (n) begin
      @(negedge clk_50);
      sample_outputs();
      game = IDLE_VIDEO;
    end
  endtask

  // one frame of random or black colours
  task automatic drive_frame(input bit black);
    logic [31:0] rnd;
    for (int ln = 0; ln < FRAME_LINES; ln++) begin
      for (int c = 0; c < LINE_LEN; c++) begin
        @(negedge clk_50);
        sample_outputs();
        rnd = $random(seed);
        drv_col = c;
        drv_line = ln;
        game.r = black ? 3'd0 : rnd[2:0];
        game.g = black ? 3'd0 : rnd[5:3];
        game.b = black ? 3'd0 : rnd[8:6];
        game.hblank = (c >= COLS);
        game.vblank = (ln >= LINES);
        // hsync low mid hblank and vsync low for one line
        game.hs_n = !(c >= 43 && c < 47);
        game.vs_n = (ln != 13);
      end
    end
  endtask

  // each thrust change must be one step in dir
  task automatic ramp_thrust(input int target, input int dir);
    logic [7:0] last;
    int cycles;
    last = thrust;
    cycles = 0;
    while (int'(thrust) != target && cycles < 262 * TICK) begin
      @(negedge clk_50);
      cycles++;
      if (thrust != last) begin
        assert (int'(thrust) == int'(last) + dir)
          else report_mismatch("thrust step", 32'(int'(last) + dir), {24'd0, thrust});
        last = thrust;
      end
    end
    if (int'(thrust) != target)
      report_problem("thrust never reached its end value");
  endtask

  initial begin
    #(WATCHDOG_TIME);
    $display("watchdog expired, the tests ran longer than their allowed time");
    $display("** FAIL **");
    $finish;
  end

  ////////////////////
  // tests

  initial begin
    logic [31:0] rnd;
    logic [15:0] key;
    logic [5:0] cab_vec;
    cont1 = '0;
    cont2 = '0;
    lamps = '0;
    game = IDLE_VIDEO;
    drv_col = 0;
    drv_line = 0;
    clear_counts();
    @(negedge clk_50);
    while (rst)
      @(negedge clk_50);

    test_name = "buttons";
    assert (buttons === 6'h3f) else report_mismatch("reset buttons", 32'h3f, {26'd0, buttons});
    assert (thrust === 8'd0) else report_mismatch("reset thrust", 32'd0, {24'd0, thrust});
    assert (video === '0) else report_mismatch("reset video", 32'd0, {5'd0, video});
    for (int i = 0; i < 6; i++) begin
      @(negedge clk_50);
      key = '0;
      key[key_bit[i]] = 1'b1;
      if (i % 2 == 0)
        cont1 = key;
      else
        cont2 = key;
      @(negedge clk_50);
      cab_vec = buttons;
      assert (cab_vec[cab_bit[i]] === 1'b1)
        else report_mismatch("cabinet bit at 1 cycle", 32'd1, {31'd0, cab_vec[cab_bit[i]]});
      @(negedge clk_50);
      cab_vec = buttons;
      assert (cab_vec[cab_bit[i]] === 1'b0)
        else report_mismatch("cabinet bit at 2 cycles", 32'd0, {31'd0, cab_vec[cab_bit[i]]});
      cont1 = '0;
      cont2 = '0;
    end
    repeat (40) begin
      @(negedge clk_50);
      rnd = $random(seed);
      cont1 = rnd[15:0];
      cont2 = rnd[31:16];
    end
    @(negedge clk_50);
    cont1 = '0;
    cont2 = '0;
    settle(4);
    end_test();

    test_name = "thrust";
    cont1.face_a = 1'b1;
    ramp_thrust(254, 1);
    repeat (3 * TICK) @(negedge clk_50);
    assert (thrust === THRUST_TOP) else report_mismatch("ceiling", 32'd254, {24'd0, thrust});
    cont1 = '0;
    cont2.face_b = 1'b1;
    ramp_thrust(0, -1);
    repeat (3 * TICK) @(negedge clk_50);
    assert (thrust === 8'd0) else report_mismatch("floor", 32'd0, {24'd0, thrust});
    // raise wins with both held
    cont1.face_a = 1'b1;
    ramp_thrust(6, 1);
    cont1 = '0;
    cont2 = '0;
    settle(4);
    end_test();

    test_name = "expand";
    clear_counts();
    drive_frame(1'b0);
    drive_frame(1'b0);
    settle(2);
    assert (de_seen == 2 * COLS * LINES)
      else report_mismatch("de count", 32'(2 * COLS * LINES), 32'(de_seen));
    end_test();

    test_name = "sync";
    clear_counts();
    drive_frame(1'b0);
    settle(2);
    assert (hs_seen == FRAME_LINES) else report_mismatch("hs pulses", 32'd15, 32'(hs_seen));
    assert (vs_seen == 1) else report_mismatch("vs pulses", 32'd1, 32'(vs_seen));
    end_test();

    test_name = "banner";
    cont1.face_select = 1'b1;
    settle(4);
    for (int combo = 0; combo < 8; combo++) begin
      lamps = combo[2:0];
      clear_counts();
      drive_frame(1'b1);
      settle(2);
      assert (lit_seen == BOX_PIXELS)
        else report_mismatch("box pixels", 32'(BOX_PIXELS), 32'(lit_seen));
    end
    // random game colour around the box
    drive_frame(1'b0);
    settle(2);
    end_test();

    test_name = "expiry";
    cont1 = '0;
    clear_counts();
    drive_frame(1'b1);
    settle(2);
    assert (lit_seen == BOX_PIXELS)
      else report_mismatch("box kept", 32'(BOX_PIXELS), 32'(lit_seen));
    clear_counts();
    drive_frame(1'b1);
    settle(2);
    assert (lit_seen == 0) else report_mismatch("box gone", 32'd0, 32'(lit_seen));
    end_test();

    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, total_errs);
    if (total_errs == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
hw/lander_pkg.sv
hw/lander_controls.sv
hw/pixel_expand.sv
hw/difficulty_banner.sv
hw/video_mixer.sv
hw/lander_shell.sv
dv/tb_clock.sv
dv/tb_lander_shell.sv

/* run.sh */
#!/bin/sh
# build and run the lander shell testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module tb_lander_shell -f verilog.f -o tb_lander_shell \
  > sim.log 2>&1 \
  && ./obj_dir/tb_lander_shell >> sim.log 2>&1 \
  || echo "build or run did not complete" >> sim.log
cat sim.log
grep -qF "** FAIL **" sim.log && echo "simulation failed" && exit 1
grep -qF "** PASS **" sim.log || { echo "simulation did not pass"; exit 1; }
echo "simulation passed"
